/* Makefile */
# Verilator build and run of the static memory controller testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module smc_tb -f files.f -o smc_sim
	out=$$(./obj_dir/smc_sim 2>&1); echo "$$out"; echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf obj_dir

/* bench/smc_clkgen.sv */
/*
  Clock and reset source for the testbench.
  hclk runs at a 10 ns period from time zero.
  rst_n is low from time zero and released on the falling edge after
  the fourth rising edge.
*/
`timescale 1ns/1ps
`default_nettype none

module smc_clkgen #(
  parameter int HALF_NS      = 5,  // Half of the 10 ns period
  parameter int RESET_CYCLES = 4
) (
  output logic hclk,
  output logic rst_n
);

  initial begin
    hclk = 1'b0;
    forever #HALF_NS hclk = ~hclk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge hclk);
    @(negedge hclk);                 // Release away from the active edge
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* bench/smc_tb.sv */
/*
  Testbench for the static memory controller.
  The SRAM model and the shadow array cover the low 64 KB only.
  Inputs change on the rising edge, outputs are read on the falling edge.
  The run stops at the first mismatch or when the cycle limit is reached.
*/
`timescale 1ns/1ps
`default_nettype none

`include "smc_cfg.svh"

module smc_tb
  import smc_pkg::*;
();

  localparam logic [31:0] SEED       = 32'hc64268e2;
  localparam logic [31:0] REG_TIMING = 32'(`SMC_REG_TIMING);
  localparam logic [31:0] REG_REFUSE = 32'(`SMC_REG_REFUSED);
  localparam logic [1:0]  APB_RD = 2'd0, APB_WR = 2'd1, AHB_RD = 2'd2, AHB_WR = 2'd3;
  localparam logic [1:0]  PLAIN = 2'b00, RND = 2'b01, B2B = 2'b10, B2B_RND = 2'b11;
  localparam logic [2:0]  SZ_B = 3'b000, SZ_H = 3'b001, SZ_W = 3'b010;
  localparam logic [1:0]  OKAY = 2'b00, ERR = 2'b01;

  typedef struct packed {
    logic [1:0]  kind;   // Bit 1 AHB, bit 0 write
    logic [1:0]  flags;  // Bit 1 next AHB step rides this data phase, bit 0 random data
    logic [31:0] addr;
    logic [2:0]  size;
    logic [31:0] data;
    logic [1:0]  resp;   // Expected AHB response
  } step_t;

  logic hclk, rst_n;
  logic [31:0] haddr, hwdata, smc_hrdata, pwdata, prdata, data_smc;
  logic [31:0] smc_addr, smc_data;
  logic [1:0]  htrans, smc_hresp;
  logic [2:0]  hsize;
  logic [4:0]  paddr;
  logic [3:0]  smc_n_be, smc_n_we;
  logic hsel, hwrite, hready, smc_hready, smc_valid, psel, penable, pwrite;
  logic smc_n_cs, smc_n_wr, smc_n_rd, smc_n_ext_oe, smc_busy;

  logic [31:0] mem [16384];     // SRAM model
  logic [31:0] shadow [16384];  // Expected memory contents
  step_t       steps [$];
  smc_timing_u cur_timing;      // Expected timing register
  logic [15:0] refused_exp;
  logic        addr_pending;    // Next address phase already on the bus
  logic [3:0]  be_seen;         // Lanes shown while chip select was low
  int rd_run, we_run, rd_width, we_width, cs_cycles, oe_cycles, valid_cnt, ahb_cnt;
  int cycle_cnt, cycle_limit;

  smc_clkgen clkgen_inst (.hclk(hclk), .rst_n(rst_n));

  smc_veneer smc_veneer_inst (.*);

  assign hready   = smc_hready;                          // Only slave on the bus
  assign data_smc = smc_n_rd ? 32'h0 : mem[smc_addr[15:2]];

  always @(posedge hclk) begin
    for (int b = 0; b < 4; b++)
      if (!smc_n_we[b]) mem[smc_addr[15:2]][8*b +: 8] <= smc_data[8*b +: 8];
  end

  //------------------------------------------------------------
  // Monitors, pre-edge values
  //------------------------------------------------------------
  always @(posedge hclk) begin
    rd_run <= smc_n_rd ? 0 : rd_run + 1;
    if (smc_n_rd && rd_run != 0) rd_width <= rd_run;     // Strobe just ended
    we_run <= (&smc_n_we) ? 0 : we_run + 1;
    if ((&smc_n_we) && we_run != 0) we_width <= we_run;
    if (!smc_n_cs) cs_cycles <= cs_cycles + 1;
    if (!smc_n_cs) be_seen <= smc_n_be;
    if (!smc_n_ext_oe) oe_cycles <= oe_cycles + 1;
    if (smc_valid) valid_cnt <= valid_cnt + 1;
    if (rst_n)
      check_data("smc_n_wr", {31'h0, smc_n_wr}, {31'h0, &smc_n_we}); // Low with any lane
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("Run did not complete within %0d cycles", cycle_limit);
      abort_run();
    end
  end

  task automatic abort_run();
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_timing(input string name, input smc_timing_u got,
                              input smc_timing_u exp);
    if (got.raw !== exp.raw) begin
      $display("[ERROR] %s: got %h, expected %h", name, got.raw, exp.raw);
      abort_run();
    end
  endtask

  task automatic check_width(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  function automatic logic [31:0] fill_word(input int i);
    return 32'h5ca1_ab1e ^ (i * 32'h9e37_79b1);           // Word index scrambled
  endfunction

  // AHB byte lanes, little endian
  function automatic logic [31:0] lane_mask(input logic [2:0] size, input logic [1:0] a);
    case (size)
      SZ_B:    return 32'h0000_00ff << {a, 3'b000};
      SZ_H:    return a[1] ? 32'hffff_0000 : 32'h0000_ffff;
      default: return 32'hffff_ffff;
    endcase
  endfunction

  // Active low lane enables of a byte mask
  function automatic logic [3:0] lane_n_be(input logic [31:0] m);
    return ~{|m[31:24], |m[23:16], |m[15:8], |m[7:0]};
  endfunction

  task automatic add_step(input logic [1:0] kind, input logic [1:0] flags,
                          input logic [31:0] addr, input logic [2:0] size,
                          input logic [31:0] data, input logic [1:0] resp);
    steps.push_back({kind, flags, addr, size, data, resp});
  endtask

  task automatic drive_address(input step_t s);
    haddr  <= s.addr;
    htrans <= 2'b10;                                     // NONSEQ
    hsel   <= 1'b1;
    hwrite <= s.kind[0];
    hsize  <= s.size;
  endtask

  //------------------------------------------------------------
  // Bus drivers
  //------------------------------------------------------------
  task automatic run_apb(input int idx);
    step_t       s;
    smc_timing_u got;
    s = steps[idx];
    @(posedge hclk);
    psel    <= 1'b1;                                     // Setup phase
    penable <= 1'b0;
    pwrite  <= s.kind[0];
    paddr   <= s.addr[`SMC_PADDR_W-1:0];
    pwdata  <= s.data;
    @(posedge hclk);
    penable <= 1'b1;
    @(negedge hclk);
    got.raw = prdata;
    @(posedge hclk);                                     // Write lands here
    psel    <= 1'b0;
    penable <= 1'b0;
    if (s.kind[0]) begin
      if (s.addr == REG_TIMING) cur_timing.raw = s.data;
    end else if (s.addr == REG_TIMING) begin
      check_timing("prdata timing", got, cur_timing);
    end else begin
      check_data("prdata refused", got.raw, {16'h0000, refused_exp});
    end
  endtask

  task automatic run_ahb(input int idx);
    step_t       s;
    logic [31:0] wdata, lanes, word;
    int          cs_before, oe_before, ws;
    s = steps[idx];
    if (!addr_pending) begin
      @(posedge hclk);
      drive_address(s);
      @(negedge hclk);
    end
    while (!smc_hready) @(negedge hclk);                 // Held off by the slave
    cs_before = cs_cycles;
    oe_before = oe_cycles;
    @(posedge hclk);                                     // Address accepted
    wdata = s.flags[0] ? $urandom() : s.data;
    hwdata <= wdata;
    addr_pending = 1'b0;
    if (s.flags[1] && idx + 1 < steps.size()) begin
      if (steps[idx + 1].kind[1]) addr_pending = 1'b1;
    end
    if (addr_pending) begin
      drive_address(steps[idx + 1]);
    end else begin
      htrans <= 2'b00;
      hsel   <= 1'b0;
    end
    @(negedge hclk);
    check_resp("smc_hresp first data cycle", smc_hresp, s.resp);
    while (!smc_hready) @(negedge hclk);
    check_resp("smc_hresp last data cycle", smc_hresp, s.resp);
    ahb_cnt++;
    check_data("smc_valid pulses", valid_cnt, ahb_cnt);
    lanes = lane_mask(s.size, s.addr[1:0]);
    word  = shadow[s.addr[15:2]];
    if (s.resp != OKAY) begin
      refused_exp++;
      check_width("smc_n_cs low cycles", cs_cycles - cs_before, 0);  // No EMI cycle
      check_width("smc_n_ext_oe low cycles", oe_cycles - oe_before, 0);
    end else begin
      ws = s.kind[0] ? int'(cur_timing.fields.wr_ws) : int'(cur_timing.fields.rd_ws);
      check_width("smc_n_cs low cycles", cs_cycles - cs_before, ws + 3);
      check_data("smc_n_be", {28'h0, be_seen}, {28'h0, lane_n_be(lanes)});
      if (s.kind[0]) begin
        check_width("smc_n_we low cycles", we_width, ws + 1);
        check_width("smc_n_ext_oe low cycles", oe_cycles - oe_before, ws + 3);
        shadow[s.addr[15:2]] = (word & ~lanes) | (wdata & lanes);
      end else begin
        check_width("smc_n_rd low cycles", rd_width, ws + 1);
        check_width("smc_n_ext_oe low cycles", oe_cycles - oe_before, 0);
        check_data("smc_hrdata", smc_hrdata & lanes, word & lanes);
      end
    end
  endtask

  //------------------------------------------------------------
  // Main sequence
  //------------------------------------------------------------
  initial begin
    void'($urandom(SEED));
    haddr   = '0;
    htrans  = 2'b00;
    hsel    = 1'b0;
    hwrite  = 1'b0;
    hsize   = SZ_W;
    hwdata  = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    rd_run    = 0;
    we_run    = 0;
    rd_width  = 0;
    we_width  = 0;
    cs_cycles = 0;
    oe_cycles = 0;
    be_seen   = '1;
    valid_cnt   = 0;
    ahb_cnt     = 0;
    cycle_cnt   = 0;
    cycle_limit = 0;
    refused_exp = '0;
    addr_pending = 1'b0;
    cur_timing.raw = `SMC_TIMING_RESET;
    for (int i = 0; i < 16384; i++) begin
      mem[i] <= fill_word(i);
      shadow[i] = fill_word(i);
    end
    // Reset value, then a write with reserved bits set
    add_step(APB_RD, PLAIN, REG_TIMING, SZ_W, 32'h0, OKAY);
    add_step(APB_WR, PLAIN, REG_TIMING, SZ_W, 32'h0005_1034, OKAY);  // rd 4, wr 3
    add_step(APB_RD, PLAIN, REG_TIMING, SZ_W, 32'h0, OKAY);
    // Words, then sub-word lanes
    add_step(AHB_WR, RND,   32'h0000_0100, SZ_W, 32'h0, OKAY);
    add_step(AHB_RD, PLAIN, 32'h0000_0100, SZ_W, 32'h0, OKAY);
    add_step(AHB_WR, PLAIN, 32'h0000_0204, SZ_W, 32'h1234_5678, OKAY);
    add_step(AHB_RD, PLAIN, 32'h0000_0204, SZ_W, 32'h0, OKAY);
    add_step(AHB_WR, PLAIN, 32'h0000_0101, SZ_B, 32'h0000_a500, OKAY);
    add_step(AHB_WR, PLAIN, 32'h0000_0206, SZ_H, 32'hbeef_0000, OKAY);
    add_step(AHB_RD, PLAIN, 32'h0000_0100, SZ_W, 32'h0, OKAY);
    add_step(AHB_RD, PLAIN, 32'h0000_0204, SZ_W, 32'h0, OKAY);
    add_step(AHB_RD, PLAIN, 32'h0000_0102, SZ_H, 32'h0, OKAY);
    // Strobe widths at other wait states
    add_step(APB_WR, PLAIN, REG_TIMING, SZ_W, 32'h0000_1000, OKAY);  // No wait states
    add_step(AHB_WR, RND,   32'h0000_0300, SZ_W, 32'h0, OKAY);
    add_step(AHB_RD, PLAIN, 32'h0000_0300, SZ_W, 32'h0, OKAY);
    add_step(APB_WR, PLAIN, REG_TIMING, SZ_W, 32'h0000_10f7, OKAY);  // rd 7, wr 15
    add_step(AHB_WR, RND,   32'h0000_0304, SZ_W, 32'h0, OKAY);
    add_step(AHB_RD, PLAIN, 32'h0000_0304, SZ_W, 32'h0, OKAY);
    // Out of region
    add_step(APB_RD, PLAIN, REG_REFUSE, SZ_W, 32'h0, OKAY);
    add_step(AHB_WR, PLAIN, 32'h0001_0000, SZ_W, 32'hdead_0001, ERR);
    add_step(AHB_RD, PLAIN, 32'h0002_0040, SZ_W, 32'h0, ERR);
    add_step(APB_RD, PLAIN, REG_REFUSE, SZ_W, 32'h0, OKAY);
    add_step(APB_WR, PLAIN, REG_TIMING, SZ_W, 32'h0000_0c21, OKAY);  // 4 KB, rd 1, wr 2
    add_step(AHB_RD, PLAIN, 32'h0000_1000, SZ_W, 32'h0, ERR);
    add_step(AHB_RD, PLAIN, 32'h0000_0ffc, SZ_W, 32'h0, OKAY);
    add_step(APB_RD, PLAIN, REG_REFUSE, SZ_W, 32'h0, OKAY);
    // Back to back, next address waits out the data phase
    add_step(AHB_WR, B2B_RND, 32'h0000_0400, SZ_W, 32'h0, OKAY);
    add_step(AHB_WR, B2B_RND, 32'h0000_0404, SZ_W, 32'h0, OKAY);
    add_step(AHB_RD, B2B,     32'h0000_0400, SZ_W, 32'h0, OKAY);
    add_step(AHB_RD, PLAIN,   32'h0000_0404, SZ_W, 32'h0, OKAY);
    add_step(APB_RD, PLAIN, REG_TIMING, SZ_W, 32'h0, OKAY);
    cycle_limit = 40 * steps.size() + 20;

    @(posedge rst_n);
    @(negedge hclk);
    check_data("emi strobes",
               {24'h0, smc_n_cs, smc_n_rd, smc_n_wr, smc_n_ext_oe, smc_n_we},
               32'h0000_00ff);
    check_data("ahb status", {27'h0, smc_hready, smc_hresp, smc_busy, smc_valid},
               32'h0000_0010);
    for (int i = 0; i < steps.size(); i++) begin
      if (steps[i].kind[1]) run_ahb(i);
      else run_apb(i);
    end
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+source
source/smc_pkg.sv
source/smc_ahb_slave.sv
source/smc_apb_regs.sv
source/smc_emi_ctrl.sv
source/smc_veneer.sv
bench/smc_clkgen.sv
bench/smc_tb.sv

/* source/smc_ahb_slave.sv */
/*
  AHB-lite slave front end of the static memory controller.
  Single transfers only; bursts are taken as back-to-back singles.
  hsize above word is treated as word. One transfer in flight at a time,
  held off by smc_hready low until the EMI side reports done.
  Addresses at or above 2**region_log2 get the two-cycle ERROR response.
*/
`timescale 1ns/1ps
`default_nettype none

`include "smc_cfg.svh"

module smc_ahb_slave
  import smc_pkg::*;
(
  input  logic                      hclk,
  input  logic                      rst_n,
  input  logic [`SMC_ADDR_W-1:0]    haddr,
  input  logic [1:0]                htrans,
  input  logic                      hsel,
  input  logic                      hwrite,
  input  logic [2:0]                hsize,
  input  logic [`SMC_DATA_W-1:0]    hwdata,
  input  logic                      hready,      // Muxed bus ready
  input  smc_timing_u               timing,
  input  logic                      done,        // EMI cycle finished
  input  logic [`SMC_DATA_W-1:0]    rd_data,
  output logic [`SMC_DATA_W-1:0]    smc_hrdata,
  output logic                      smc_hready,
  output logic [1:0]                smc_hresp,
  output logic                      smc_valid,   // Pulse per accepted address
  output logic                      start,
  output logic [`SMC_ADDR_W-1:0]    acc_addr,
  output logic                      acc_write,
  output logic [`SMC_DATA_W/8-1:0]  acc_n_be,    // Active low lanes
  output logic [`SMC_DATA_W-1:0]    acc_wdata,
  output logic                      refused      // Pulse per ERROR transfer
);

  localparam logic [2:0] S_IDLE  = 3'd0;
  localparam logic [2:0] S_START = 3'd1; // First data-phase cycle
  localparam logic [2:0] S_WAIT  = 3'd2; // EMI cycle running
  localparam logic [2:0] S_ERR1  = 3'd3; // ERROR, hready low
  localparam logic [2:0] S_ERR2  = 3'd4; // ERROR, hready high

  localparam logic [1:0] HRESP_OKAY  = 2'b00;
  localparam logic [1:0] HRESP_ERROR = 2'b01;

  logic [2:0]                state;
  logic                      accept;     // Address phase taken this edge
  logic                      in_region;
  logic [`SMC_DATA_W/8-1:0]  be;         // Active high lanes
  logic                      xfer_open;  // start sent, done not yet seen

  assign accept    = hsel && htrans[1] && hready; // NONSEQ or SEQ
  assign in_region = (haddr >> timing.fields.region_log2) == '0;

  // Byte lanes from size and low address bits, little endian
  always_comb begin
    case (hsize)
      3'b000:  be = 4'b0001 << haddr[1:0];
      3'b001:  be = haddr[1] ? 4'b1100 : 4'b0011;
      default: be = 4'b1111;
    endcase
  end

  //------------------------------------------------------------
  // Response FSM
  //------------------------------------------------------------
  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= S_IDLE;
      smc_hready <= 1'b1;
      smc_hresp  <= HRESP_OKAY;
      smc_valid  <= 1'b0;
      start      <= 1'b0;
      refused    <= 1'b0;
    end else begin
      smc_valid <= 1'b0;                          // Pulses by default
      start     <= 1'b0;
      refused   <= 1'b0;
      case (state)
        S_IDLE, S_ERR2: begin                     // Ready for an address
          smc_hresp <= HRESP_OKAY;
          state     <= S_IDLE;
          if (accept) begin
            smc_valid  <= 1'b1;
            smc_hready <= 1'b0;
            if (in_region) begin
              state <= S_START;
            end else begin
              state     <= S_ERR1;
              smc_hresp <= HRESP_ERROR;
              refused   <= 1'b1;
            end
          end
        end
        S_START: begin
          start <= 1'b1;                          // hwdata captured alongside
          state <= S_WAIT;
        end
        S_WAIT: begin
          if (done) begin
            smc_hready <= 1'b1;
            state      <= S_IDLE;
          end
        end
        S_ERR1: begin
          smc_hready <= 1'b1;                     // Second ERROR cycle
          state      <= S_ERR2;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Address, data and read-back capture
  always_ff @(posedge hclk) begin
    if (accept) begin
      acc_addr  <= haddr;
      acc_write <= hwrite;
      acc_n_be  <= ~be;
    end
    if (state == S_START) acc_wdata <= hwdata;  // Valid in first data cycle
    if (done) smc_hrdata <= rd_data;
  end

  // Tracks the EMI handshake across both blocks
  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) xfer_open <= 1'b0;
    else if (start) xfer_open <= 1'b1;
    else if (done) xfer_open <= 1'b0;
  end

  a_single_outstanding: assert property (@(posedge hclk) disable iff (!rst_n)
    start |-> !xfer_open)
    else $error("start issued before done of previous transfer");

endmodule

`default_nettype wire

/* source/smc_apb_regs.sv */
/*
  APB register file of the static memory controller.
  No wait states; reads are combinational within the access.
  The refused counter is 16 bits, saturates, and ignores writes.
*/
`timescale 1ns/1ps
`default_nettype none

`include "smc_cfg.svh"

module smc_apb_regs
  import smc_pkg::*;
(
  input  logic                    hclk,
  input  logic                    rst_n,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [`SMC_PADDR_W-1:0] paddr,
  input  logic [`SMC_DATA_W-1:0]  pwdata,
  input  logic                    refused,   // Pulse from the AHB side
  output logic [`SMC_DATA_W-1:0]  prdata,
  output smc_timing_u             timing
);

  logic        wr_en;
  logic [15:0] refused_cnt;

  assign wr_en = psel && penable && pwrite;  // Access phase write

  //------------------------------------------------------------
  // Registers
  //------------------------------------------------------------
  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      timing.raw  <= `SMC_TIMING_RESET;
      refused_cnt <= '0;
    end else begin
      if (wr_en && paddr == `SMC_REG_TIMING) timing.raw <= pwdata;
      if (refused && refused_cnt != 16'hffff)
        refused_cnt <= refused_cnt + 16'd1;     // Sticks at all ones
    end
  end

  // Read mux, unmapped offsets read zero
  always_comb begin
    case (paddr)
      `SMC_REG_TIMING:  prdata = timing.raw;
      `SMC_REG_REFUSED: prdata = {16'h0000, refused_cnt};
      default:          prdata = '0;
    endcase
  end

  // Every access phase follows a setup phase
  a_apb_setup: assert property (@(posedge hclk) disable iff (!rst_n)
    $rose(penable) |-> psel && $past(psel))
    else $error("penable raised without a setup phase");

endmodule

`default_nettype wire

/* source/smc_cfg.svh */
/*
  Static memory controller build constants.
  Data path is fixed at 32 bits and the byte-lane decode assumes 4 lanes.
  Timing register reset: rd_ws 2, wr_ws 1, region 64 KB (log2 16).
*/
`ifndef SMC_CFG_SVH
`define SMC_CFG_SVH

// Bus widths
`define SMC_ADDR_W        32
`define SMC_DATA_W        32
`define SMC_PADDR_W       5

// APB register map
`define SMC_REG_TIMING    5'h00        // Timing word, read/write
`define SMC_REG_REFUSED   5'h04        // Refused AHB transfers, read only

// Wait-state field width and timing reset value
`define SMC_WS_W          4
`define SMC_TIMING_RESET  32'h0000_1012 // region_log2 16, wr_ws 1, rd_ws 2

`endif

/* source/smc_emi_ctrl.sv */
/*
  External memory interface cycle generator.
  One chip select. Each start gives setup (1), strobe (ws+1), hold (1).
  start is only taken while idle; the AHB side guarantees this.
  All strobes are registered so the pins do not glitch.
*/
`timescale 1ns/1ps
`default_nettype none

`include "smc_cfg.svh"

module smc_emi_ctrl
  import smc_pkg::*;
(
  input  logic                      hclk,
  input  logic                      rst_n,
  input  logic                      start,
  input  logic [`SMC_ADDR_W-1:0]    acc_addr,
  input  logic                      acc_write,
  input  logic [`SMC_DATA_W/8-1:0]  acc_n_be,
  input  logic [`SMC_DATA_W-1:0]    acc_wdata,
  input  smc_timing_u               timing,
  input  logic [`SMC_DATA_W-1:0]    data_smc,     // Read data from memory
  output logic                      done,         // High in the hold cycle
  output logic [`SMC_DATA_W-1:0]    rd_data,
  output logic [`SMC_ADDR_W-1:0]    smc_addr,
  output logic [`SMC_DATA_W-1:0]    smc_data,
  output logic [`SMC_DATA_W/8-1:0]  smc_n_be,
  output logic                      smc_n_cs,
  output logic                      smc_n_wr,
  output logic [`SMC_DATA_W/8-1:0]  smc_n_we,
  output logic                      smc_n_rd,
  output logic                      smc_n_ext_oe, // Drive data pins, writes
  output logic                      smc_busy
);

  localparam logic [1:0] S_IDLE   = 2'd0;
  localparam logic [1:0] S_SETUP  = 2'd1;
  localparam logic [1:0] S_STROBE = 2'd2;
  localparam logic [1:0] S_HOLD   = 2'd3;

  logic [1:0]                state, state_nxt;
  logic [`SMC_WS_W-1:0]      ws_cnt;      // Strobe cycles left minus one
  logic                      wr_q;
  logic                      wr_sel;      // Direction seen by the pin logic
  logic [`SMC_DATA_W/8-1:0]  n_be_sel;
  logic                      strobe_nxt;

  always_comb begin
    state_nxt = state;
    case (state)
      S_IDLE:   if (start) state_nxt = S_SETUP;
      S_SETUP:  state_nxt = S_STROBE;
      S_STROBE: if (ws_cnt == '0) state_nxt = S_HOLD;
      default:  state_nxt = S_IDLE;           // Hold lasts one cycle
    endcase
  end

  // Take the new request straight from the inputs when leaving idle
  assign wr_sel     = (state == S_IDLE) ? acc_write : wr_q;
  assign n_be_sel   = (state == S_IDLE) ? acc_n_be : smc_n_be;
  assign strobe_nxt = (state_nxt == S_STROBE);

  //------------------------------------------------------------
  // State, wait counter and pins
  //------------------------------------------------------------
  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= S_IDLE;
      ws_cnt       <= '0;
      smc_n_cs     <= 1'b1;
      smc_n_be     <= '1;
      smc_n_rd     <= 1'b1;
      smc_n_wr     <= 1'b1;
      smc_n_we     <= '1;
      smc_n_ext_oe <= 1'b1;
      smc_busy     <= 1'b0;
      done         <= 1'b0;
    end else begin
      state <= state_nxt;
      if (state == S_SETUP)
        ws_cnt <= wr_q ? timing.fields.wr_ws : timing.fields.rd_ws;
      else if (state == S_STROBE)
        ws_cnt <= ws_cnt - 1'b1;
      smc_n_cs     <= (state_nxt == S_IDLE);    // ws+3 cycles low
      smc_n_be     <= (state_nxt == S_IDLE) ? '1 : n_be_sel;
      smc_n_ext_oe <= !(state_nxt != S_IDLE && wr_sel);
      smc_n_rd     <= !(strobe_nxt && !wr_sel);
      smc_n_wr     <= !(strobe_nxt && wr_sel);
      smc_n_we     <= (strobe_nxt && wr_sel) ? n_be_sel : '1;
      smc_busy     <= (state_nxt != S_IDLE);
      done         <= (state_nxt == S_HOLD);
    end
  end

  // Request and read data latches
  always_ff @(posedge hclk) begin
    if (state == S_IDLE && start) begin
      smc_addr <= acc_addr;
      smc_data <= acc_wdata;
      wr_q     <= acc_write;
    end
    if (state == S_STROBE && ws_cnt == '0 && !wr_q)
      rd_data <= data_smc;                      // Last strobe cycle
  end

  a_rd_wr_excl: assert property (@(posedge hclk) disable iff (!rst_n)
    smc_n_rd || smc_n_wr)
    else $error("read and write strobes low together");

endmodule

`default_nettype wire

/* source/smc_pkg.sv */
/*
  Shared types of the static memory controller.
  The timing word is seen raw by APB and as fields by the AHB and EMI sides.
*/
`default_nettype none

`include "smc_cfg.svh"

package smc_pkg;

  // Timing register layout, bit 0 at the bottom
  typedef struct packed {
    logic [18:0]           rsvd;        // Reads back as written, no function
    logic [4:0]            region_log2; // Region is 2**region_log2 bytes
    logic [`SMC_WS_W-1:0]  wr_ws;       // Extra write strobe cycles
    logic [`SMC_WS_W-1:0]  rd_ws;       // Extra read strobe cycles
  } smc_timing_t;

  typedef union packed {
    logic [31:0]  raw;    // APB view
    smc_timing_t  fields; // Decoded view
  } smc_timing_u;

endpackage

`default_nettype wire

/* source/smc_veneer.sv */
/*
  Chip-level top of the static memory controller.
  APB runs on hclk; one asynchronous active-low reset for all logic.
  No scan ports. Internal nets share names with the block ports.
*/
`timescale 1ns/1ps
`default_nettype none

`include "smc_cfg.svh"

module smc_veneer
  import smc_pkg::*;
(
  input  logic                      hclk,
  input  logic                      rst_n,
  // AHB-lite slave
  input  logic [`SMC_ADDR_W-1:0]    haddr,
  input  logic [1:0]                htrans,
  input  logic                      hsel,
  input  logic                      hwrite,
  input  logic [2:0]                hsize,
  input  logic [`SMC_DATA_W-1:0]    hwdata,
  input  logic                      hready,
  output logic [`SMC_DATA_W-1:0]    smc_hrdata,
  output logic                      smc_hready,
  output logic [1:0]                smc_hresp,
  output logic                      smc_valid,
  // APB registers
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [`SMC_PADDR_W-1:0]   paddr,
  input  logic [`SMC_DATA_W-1:0]    pwdata,
  output logic [`SMC_DATA_W-1:0]    prdata,
  // External memory
  input  logic [`SMC_DATA_W-1:0]    data_smc,
  output logic [`SMC_ADDR_W-1:0]    smc_addr,
  output logic [`SMC_DATA_W-1:0]    smc_data,
  output logic [`SMC_DATA_W/8-1:0]  smc_n_be,
  output logic                      smc_n_cs,
  output logic                      smc_n_wr,
  output logic [`SMC_DATA_W/8-1:0]  smc_n_we,
  output logic                      smc_n_rd,
  output logic                      smc_n_ext_oe,
  output logic                      smc_busy
);

  //------------------------------------------------------------
  // Block interconnect
  //------------------------------------------------------------
  smc_timing_u               timing;     // Level from APB to both blocks
  logic                      start, done, refused;
  logic [`SMC_ADDR_W-1:0]    acc_addr;
  logic                      acc_write;
  logic [`SMC_DATA_W/8-1:0]  acc_n_be;
  logic [`SMC_DATA_W-1:0]    acc_wdata;
  logic [`SMC_DATA_W-1:0]    rd_data;

  // Ports match net names one to one
  smc_ahb_slave i_ahb_slave (.*);
  smc_apb_regs  i_apb_regs  (.*);
  smc_emi_ctrl  i_emi_ctrl  (.*);

endmodule

`default_nettype wire
